//--- hdl/pagerank_pkg.sv
/*
 * shared types for the pagerank scheduler
 * word and element widths, lane count, opcode and FSM enums
 */

`default_nettype none

package pagerank_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [7:0]  rank_t;

  // elements per memory word
  localparam int lanes = 4;

  // ----------------------------------------
  // opcodes
  // ----------------------------------------
  typedef enum logic {
    pr_rd = 1'b0,
    pr_wr = 1'b1
  } pr_type_t;

  typedef enum logic [2:0] {
    mem_rd = 3'd0,
    mem_wr = 3'd1
  } mem_type_t;

  // host config addresses
  typedef enum logic [31:0] {
    cfg_go     = 32'd0,
    cfg_base_g = 32'd1,
    cfg_base_r = 32'd2
  } cfg_addr_t;

  // sequencer FSM
  typedef enum logic [2:0] {
    st_idle,
    st_read_r,
    st_wait_r,
    st_read_g,
    st_wait_g,
    st_write,
    st_wait_w
  } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/rank_buf_if.sv
/*
 * sequencer, buffer and MAC connection
 */

`default_nettype none

interface rank_buf_if #(
  parameter int n = 8
);

  // index widths, never below one bit
  localparam int row_w   = (n > 1) ? $clog2(n) : 1;
  localparam int slice_w = (n / pagerank_pkg::lanes > 1) ? $clog2(n / pagerank_pkg::lanes) : 1;

  // strobes and indices from the sequencer
  logic               slice_load;
  logic               acc_en;
  logic               acc_first;
  logic [row_w-1:0]   row;
  logic [slice_w-1:0] wb_slice;

  // buffer outputs
  pagerank_pkg::rank_t [pagerank_pkg::lanes-1:0] r_slice;
  pagerank_pkg::rank_t acc_in;
  pagerank_pkg::word_t wb_word;

  // MAC result
  pagerank_pkg::rank_t acc_sum;

  modport seq (
    output slice_load, acc_en, acc_first, row, wb_slice,
    input  wb_word
  );

  // buf is a reserved word, hence buffer
  modport buffer (
    input  slice_load, acc_en, row, wb_slice, acc_sum,
    output r_slice, acc_in, wb_word
  );

  modport mac (
    input  r_slice, acc_in, acc_first,
    output acc_sum
  );

endinterface

`default_nettype wire

//--- hdl/rank_sequencer.sv
/*
 * host config registers and control FSM
 * slice and row counters, memory address generation
 */

`default_nettype none

module rank_sequencer #(
  parameter int n = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  // host request and response
  input  logic                    pr_req_val,
  output logic                    pr_req_rdy,
  input  pagerank_pkg::pr_type_t  pr_req_type,
  input  pagerank_pkg::word_t     pr_req_addr,
  input  pagerank_pkg::word_t     pr_req_data,
  output logic                    pr_resp_val,
  input  logic                    pr_resp_rdy,
  output pagerank_pkg::pr_type_t  pr_resp_type,
  output pagerank_pkg::word_t     pr_resp_data,
  // memory request and response
  output logic                    mem_req_val,
  input  logic                    mem_req_rdy,
  output pagerank_pkg::mem_type_t mem_req_type,
  output pagerank_pkg::word_t     mem_req_addr,
  output pagerank_pkg::word_t     mem_req_data,
  input  logic                    mem_resp_val,
  output logic                    mem_resp_rdy,
  rank_buf_if.seq                 bus
);

  localparam int row_w   = (n > 1) ? $clog2(n) : 1;
  localparam int slice_w = (n / pagerank_pkg::lanes > 1) ? $clog2(n / pagerank_pkg::lanes) : 1;
  localparam logic [row_w-1:0]   last_row   = row_w'(n - 1);
  localparam logic [slice_w-1:0] last_slice = slice_w'(n / pagerank_pkg::lanes - 1);

  pagerank_pkg::seq_state_t state;
  pagerank_pkg::word_t      base_g;
  pagerank_pkg::word_t      base_r;
  logic [slice_w-1:0]       slice;
  logic [row_w-1:0]         row;

  logic                cfg_wr;
  logic                mem_req_go;
  logic                mem_resp_go;
  pagerank_pkg::word_t r_addr;
  pagerank_pkg::word_t g_addr;

  // ----------------------------------------
  // handshakes and addresses
  // ----------------------------------------
  // host transfer is request and response in one cycle
  assign cfg_wr      = pr_req_val && pr_req_rdy && (pr_req_type == pagerank_pkg::pr_wr);
  assign mem_req_go  = mem_req_val && mem_req_rdy;
  assign mem_resp_go = mem_resp_val && mem_resp_rdy;

  // R slice c at base_r + 4c
  assign r_addr = base_r + pagerank_pkg::word_t'(slice) * pagerank_pkg::word_t'(pagerank_pkg::lanes);
  // row j of G, word c
  assign g_addr = base_g + pagerank_pkg::word_t'(row) * pagerank_pkg::word_t'(n)
                + pagerank_pkg::word_t'(slice) * pagerank_pkg::word_t'(pagerank_pkg::lanes);

  // ----------------------------------------
  // state and counters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= pagerank_pkg::st_idle;
      base_g <= '0;
      base_r <= '0;
      slice  <= '0;
      row    <= '0;
    end else begin
      case (state)
        pagerank_pkg::st_idle: begin
          if (cfg_wr && pr_req_addr == pagerank_pkg::cfg_base_g) begin
            base_g <= pr_req_data;
          end
          if (cfg_wr && pr_req_addr == pagerank_pkg::cfg_base_r) begin
            base_r <= pr_req_data;
          end
          // go starts a run from slice 0
          if (cfg_wr && pr_req_addr == pagerank_pkg::cfg_go) begin
            slice <= '0;
            row   <= '0;
            state <= pagerank_pkg::st_read_r;
          end
        end
        pagerank_pkg::st_read_r: begin
          if (mem_req_go) state <= pagerank_pkg::st_wait_r;
        end
        pagerank_pkg::st_wait_r: begin
          if (mem_resp_go) begin
            row   <= '0;
            state <= pagerank_pkg::st_read_g;
          end
        end
        pagerank_pkg::st_read_g: begin
          if (mem_req_go) state <= pagerank_pkg::st_wait_g;
        end
        pagerank_pkg::st_wait_g: begin
          if (mem_resp_go) begin
            if (row != last_row) begin
              row   <= row + 1'b1;
              state <= pagerank_pkg::st_read_g;
            end else if (slice != last_slice) begin
              // next R slice
              slice <= slice + 1'b1;
              state <= pagerank_pkg::st_read_r;
            end else begin
              // all slices done, write back from slice 0
              slice <= '0;
              state <= pagerank_pkg::st_write;
            end
          end
        end
        pagerank_pkg::st_write: begin
          if (mem_req_go) state <= pagerank_pkg::st_wait_w;
        end
        pagerank_pkg::st_wait_w: begin
          if (mem_resp_go) begin
            if (slice == last_slice) begin
              state <= pagerank_pkg::st_idle;
            end else begin
              slice <= slice + 1'b1;
              state <= pagerank_pkg::st_write;
            end
          end
        end
        default: state <= pagerank_pkg::st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  // host answers only while idle
  assign pr_req_rdy   = (state == pagerank_pkg::st_idle) && pr_resp_rdy;
  assign pr_resp_val  = (state == pagerank_pkg::st_idle) && pr_req_val;
  assign pr_resp_type = pr_req_type;
  assign pr_resp_data = (pr_req_type == pagerank_pkg::pr_wr) ? 32'd0 : 32'd1;

  assign mem_req_val  = (state == pagerank_pkg::st_read_r) || (state == pagerank_pkg::st_read_g)
                     || (state == pagerank_pkg::st_write);
  assign mem_resp_rdy = (state == pagerank_pkg::st_wait_r) || (state == pagerank_pkg::st_wait_g)
                     || (state == pagerank_pkg::st_wait_w);
  assign mem_req_type = (state == pagerank_pkg::st_write) ? pagerank_pkg::mem_wr
                                                          : pagerank_pkg::mem_rd;
  assign mem_req_addr = (state == pagerank_pkg::st_read_g) ? g_addr : r_addr;
  assign mem_req_data = (state == pagerank_pkg::st_write) ? bus.wb_word : '0;

  // buffer strobes on response transfers
  assign bus.slice_load = (state == pagerank_pkg::st_wait_r) && mem_resp_go;
  assign bus.acc_en     = (state == pagerank_pkg::st_wait_g) && mem_resp_go;
  // first slice overwrites the stale result
  assign bus.acc_first  = bus.acc_en && (slice == '0);
  assign bus.row        = row;
  assign bus.wb_slice   = slice;

endmodule

`default_nettype wire

//--- hdl/rank_buffer.sv
/*
 * R slice register and n result registers
 * accumulate writes, writeback word select
 */

`default_nettype none

module rank_buffer #(
  parameter int n = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  pagerank_pkg::word_t mem_resp_data,
  rank_buf_if.buffer          bus
);

  pagerank_pkg::rank_t [pagerank_pkg::lanes-1:0] r_slice;
  pagerank_pkg::rank_t result [n];

  // ----------------------------------------
  // R slice, lowest byte is lane 0
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      r_slice <= '0;
    end else if (bus.slice_load) begin
      for (int i = 0; i < pagerank_pkg::lanes; i++) begin
        r_slice[i] <= mem_resp_data[8*i +: 8];
      end
    end
  end

  // ----------------------------------------
  // result registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int j = 0; j < n; j++) begin
        result[j] <= '0;
      end
    end else if (bus.acc_en) begin
      result[bus.row] <= bus.acc_sum;
    end
  end

  assign bus.r_slice = r_slice;
  // running sum of the current row
  assign bus.acc_in  = result[bus.row];

  // four results of the writeback slice, packed lowest first
  always_comb begin
    for (int i = 0; i < pagerank_pkg::lanes; i++) begin
      bus.wb_word[8*i +: 8] = result[int'(bus.wb_slice) * pagerank_pkg::lanes + i];
    end
  end

endmodule

`default_nettype wire

//--- hdl/rank_mac.sv
/*
 * four-lane multiply and accumulate, modulo 256
 */

`default_nettype none

module rank_mac (
  input  pagerank_pkg::word_t mem_resp_data,
  rank_buf_if.mac             bus
);

  always_comb begin
    pagerank_pkg::rank_t sum;
    // old result dropped on the first slice
    sum = bus.acc_first ? '0 : bus.acc_in;
    // G byte i pairs with R lane i
    for (int i = 0; i < pagerank_pkg::lanes; i++) begin
      sum = sum + pagerank_pkg::rank_t'(mem_resp_data[8*i +: 8] * bus.r_slice[i]);
    end
    bus.acc_sum = sum;
  end

endmodule

`default_nettype wire

//--- hdl/pagerank_scheduler.sv
/*
 * pagerank scheduler top level
 * sequencer, buffer and MAC over one interface
 */

`default_nettype none

module pagerank_scheduler #(
  parameter int n = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  // host port
  input  logic                    pr_req_val,
  output logic                    pr_req_rdy,
  input  pagerank_pkg::pr_type_t  pr_req_type,
  input  pagerank_pkg::word_t     pr_req_addr,
  input  pagerank_pkg::word_t     pr_req_data,
  output logic                    pr_resp_val,
  input  logic                    pr_resp_rdy,
  output pagerank_pkg::pr_type_t  pr_resp_type,
  output pagerank_pkg::word_t     pr_resp_data,
  // memory port
  output logic                    mem_req_val,
  input  logic                    mem_req_rdy,
  output pagerank_pkg::mem_type_t mem_req_type,
  output pagerank_pkg::word_t     mem_req_addr,
  output pagerank_pkg::word_t     mem_req_data,
  input  logic                    mem_resp_val,
  output logic                    mem_resp_rdy,
  input  pagerank_pkg::word_t     mem_resp_data
);

  rank_buf_if #(.n(n)) bus ();

  rank_sequencer #(.n(n)) u_seq (
    .clk          (clk),
    .reset        (reset),
    .pr_req_val   (pr_req_val),
    .pr_req_rdy   (pr_req_rdy),
    .pr_req_type  (pr_req_type),
    .pr_req_addr  (pr_req_addr),
    .pr_req_data  (pr_req_data),
    .pr_resp_val  (pr_resp_val),
    .pr_resp_rdy  (pr_resp_rdy),
    .pr_resp_type (pr_resp_type),
    .pr_resp_data (pr_resp_data),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_type (mem_req_type),
    .mem_req_addr (mem_req_addr),
    .mem_req_data (mem_req_data),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .bus          (bus.seq)
  );

  // slice and results, updated on response transfers
  rank_buffer #(.n(n)) u_buffer (
    .clk           (clk),
    .reset         (reset),
    .mem_resp_data (mem_resp_data),
    .bus           (bus.buffer)
  );

  // G word used as it arrives
  rank_mac u_mac (
    .mem_resp_data (mem_resp_data),
    .bus           (bus.mac)
  );

endmodule

`default_nettype wire

//--- testbench/tb_pagerank_mem.sv
/*
 * byte-addressed memory model for the scheduler memory port
 * request stall and response latency drawn from a Galois LFSR
 */

`default_nettype none

module tb_pagerank_mem (
  input  logic                    clk,
  input  logic                    mem_req_val,
  output logic                    mem_req_rdy,
  input  pagerank_pkg::mem_type_t mem_req_type,
  input  pagerank_pkg::word_t     mem_req_addr,
  input  pagerank_pkg::word_t     mem_req_data,
  output logic                    mem_resp_val,
  input  logic                    mem_resp_rdy,
  output pagerank_pkg::word_t     mem_resp_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // preloaded and read back by the top
  logic [7:0]  bytes [256];
  logic [15:0] lfsr = 16'd38742;

  logic                    req_go;
  logic                    resp_go;
  logic                    val;
  logic                    waiting;
  pagerank_pkg::mem_type_t kind;
  pagerank_pkg::word_t     addr;
  pagerank_pkg::word_t     data;
  int                      stall;
  int                      delay;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // 0 to 3 cycles, one LFSR step per bit
  function automatic int draw_count();
    int v;
    v = 0;
    for (int b = 0; b < 2; b++) begin
      v = v * 2 + int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  initial begin
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    waiting       = 1'b0;
    delay         = 0;
    stall         = draw_count();
    forever begin
      // DUT outputs have settled by the falling edge
      @(negedge clk);
      req_go  = mem_req_val && mem_req_rdy;
      resp_go = mem_resp_val && mem_resp_rdy;
      val     = mem_req_val;
      kind    = mem_req_type;
      addr    = mem_req_addr;
      data    = mem_req_data;
      @(posedge clk);
      #1;
      if (resp_go) begin
        mem_resp_val = 1'b0;
      end
      if (req_go) begin
        mem_req_rdy = 1'b0;
        // writes answer with data 0
        for (int i = 0; i < pagerank_pkg::lanes; i++) begin
          if (kind == pagerank_pkg::mem_wr) begin
            bytes[8'(addr + i)] = data[8*i +: 8];
          end
          mem_resp_data[8*i +: 8] = (kind == pagerank_pkg::mem_wr) ? 8'h00 : bytes[8'(addr + i)];
        end
        waiting = 1'b1;
        delay   = draw_count();
        stall   = draw_count();
      end else if (waiting) begin
        if (delay == 0) begin
          mem_resp_val = 1'b1;
          waiting      = 1'b0;
        end else begin
          delay--;
        end
      end else if (val && !mem_resp_val && !mem_req_rdy) begin
        // request held stalled for a while
        if (stall == 0) begin
          mem_req_rdy = 1'b1;
        end else begin
          stall--;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/pagerank_asserts.sv
/*
 * concurrent checks on the scheduler memory and host handshakes
 */

`default_nettype none

module pagerank_asserts (
  input logic                    clk,
  input logic                    reset,
  input logic                    mem_req_val,
  input logic                    mem_req_rdy,
  input logic                    mem_resp_val,
  input logic                    mem_resp_rdy,
  input logic                    pr_resp_val,
  input pagerank_pkg::mem_type_t mem_req_type,
  input pagerank_pkg::word_t     mem_req_addr,
  input pagerank_pkg::word_t     mem_req_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // failure flags read by the testbench
  logic hold_bad    = 1'b0;
  logic overlap_bad = 1'b0;
  logic host_bad    = 1'b0;

  // high from a request transfer to its response transfer
  logic pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      pending <= 1'b1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      pending <= 1'b0;
    end
  end

  // stalled request keeps its fields
  req_hold: assert property (@(posedge clk) disable iff (reset)
      mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_type)
      && $stable(mem_req_addr) && $stable(mem_req_data))
    else begin
      hold_bad = 1'b1;
      $error("memory request changed during a stall");
    end

  // one transaction at a time
  // response ready only while a request is pending
  req_resp_excl: assert property (@(posedge clk) disable iff (reset)
      pending ? !mem_req_val : !mem_resp_rdy)
    else begin
      overlap_bad = 1'b1;
      $error("memory request and response ready out of turn");
    end

  // host is served only while no memory transaction is in flight
  host_quiet: assert property (@(posedge clk) disable iff (reset)
      (mem_req_val || pending) |-> !pr_resp_val)
    else begin
      host_bad = 1'b1;
      $error("host response valid during a memory transaction");
    end

endmodule

bind pagerank_scheduler pagerank_asserts u_asserts (.*);

`default_nettype wire

//--- testbench/tb_pagerank.sv
/*
 * testbench top for the pagerank scheduler
 * clock, reset, host stimulus, reference model and checks
 */

`default_nettype none

module tb_pagerank;
  timeunit 1ns;
  timeprecision 100ps;

  // 3 runs of 20 transactions at up to 20 cycles each, plus reset and host traffic
  localparam int max_cycles = 2000;
  localparam int n          = 8;

  logic                    clk;
  logic                    reset;
  logic                    pr_req_val;
  logic                    pr_req_rdy;
  pagerank_pkg::pr_type_t  pr_req_type;
  pagerank_pkg::word_t     pr_req_addr;
  pagerank_pkg::word_t     pr_req_data;
  logic                    pr_resp_val;
  logic                    pr_resp_rdy;
  pagerank_pkg::pr_type_t  pr_resp_type;
  pagerank_pkg::word_t     pr_resp_data;
  logic                    mem_req_val;
  logic                    mem_req_rdy;
  pagerank_pkg::mem_type_t mem_req_type;
  pagerank_pkg::word_t     mem_req_addr;
  pagerank_pkg::word_t     mem_req_data;
  logic                    mem_resp_val;
  logic                    mem_resp_rdy;
  pagerank_pkg::word_t     mem_resp_data;

  // expected writebacks, two per run
  pagerank_pkg::word_t exp_addr [6];
  pagerank_pkg::word_t exp_data [6];
  int                  wr_total = 0;
  int                  cycles   = 0;
  logic [15:0]         lfsr     = 16'd38742;

  pagerank_scheduler #(.n(n)) dut (.*);
  tb_pagerank_mem mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= max_cycles) begin
        $display("timeout: the scheduler runs did not finish within %0d cycles", max_cycles);
        $display(">>> FAIL");
        $fatal(1, "timeout");
      end
    end
  end

  task automatic check(input string name, input pagerank_pkg::word_t expected,
                       input pagerank_pkg::word_t actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // lowest bit first, one step per bit
  function automatic logic [7:0] random_byte();
    logic [7:0] v;
    for (int b = 0; b < 8; b++) begin
      v[b] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // ----------------------------------------
  // reference, sum over k of G[j][k] * R[k] mod 256
  // ----------------------------------------
  function automatic pagerank_pkg::word_t ref_word(input int bg, input int br, input int c);
    pagerank_pkg::word_t w;
    pagerank_pkg::rank_t acc;
    for (int l = 0; l < pagerank_pkg::lanes; l++) begin
      acc = '0;
      for (int k = 0; k < n; k++) begin
        acc = acc + pagerank_pkg::rank_t'(mem.bytes[8'(bg + (4 * c + l) * n + k)]
                                         * mem.bytes[8'(br + k)]);
      end
      w[8*l +: 8] = acc;
    end
    return w;
  endfunction

  // each write checked as it transfers
  always @(negedge clk) begin
    if (mem_req_val && mem_req_rdy && mem_req_type == pagerank_pkg::mem_wr) begin
      check("writeback within expected count", 32'd1, 32'(wr_total < 6));
      check("writeback address", exp_addr[wr_total], mem_req_addr);
      check("writeback data", exp_data[wr_total], mem_req_data);
      wr_total++;
    end
  end

  // ----------------------------------------
  // host transfers
  // ----------------------------------------
  task automatic host_xfer(input pagerank_pkg::pr_type_t kind, input pagerank_pkg::word_t addr,
                           input pagerank_pkg::word_t data, output pagerank_pkg::pr_type_t rtype,
                           output pagerank_pkg::word_t rdata);
    pr_req_val  = 1'b1;
    pr_req_type = kind;
    pr_req_addr = addr;
    pr_req_data = data;
    @(negedge clk);
    while (!(pr_req_rdy && pr_resp_val)) begin
      @(negedge clk);
    end
    rtype = pr_resp_type;
    rdata = pr_resp_data;
    @(posedge clk);
    #1;
    pr_req_val = 1'b0;
  endtask

  task automatic host_write(input string name, input pagerank_pkg::word_t addr,
                            input pagerank_pkg::word_t data);
    pagerank_pkg::pr_type_t rtype;
    pagerank_pkg::word_t    rdata;
    host_xfer(pagerank_pkg::pr_wr, addr, data, rtype, rdata);
    check({name, " response type"}, 32'(pagerank_pkg::pr_wr), 32'(rtype));
    check({name, " response data"}, 32'd0, rdata);
  endtask

  task automatic host_read(input string name);
    pagerank_pkg::pr_type_t rtype;
    pagerank_pkg::word_t    rdata;
    host_xfer(pagerank_pkg::pr_rd, pagerank_pkg::cfg_go, '0, rtype, rdata);
    check({name, " response type"}, 32'(pagerank_pkg::pr_rd), 32'(rtype));
    check({name, " response data"}, 32'd1, rdata);
  endtask

  task automatic run_once(input string name, input int run, input bit set_bases,
                          input pagerank_pkg::word_t bg, input pagerank_pkg::word_t br);
    pagerank_pkg::word_t got;
    for (int c = 0; c < n / pagerank_pkg::lanes; c++) begin
      exp_addr[2*run + c] = br + 4 * c;
      exp_data[2*run + c] = ref_word(int'(bg), int'(br), c);
    end
    if (set_bases) begin
      host_write({name, " base_g"}, pagerank_pkg::cfg_base_g, bg);
      host_write({name, " base_r"}, pagerank_pkg::cfg_base_r, br);
    end
    host_write({name, " go"}, pagerank_pkg::cfg_go, '0);
    // blocks until the FSM is idle again
    host_read({name, " blocking read"});
    check({name, " write count"}, 32'(2*run + 2), 32'(wr_total));
    for (int c = 0; c < n / pagerank_pkg::lanes; c++) begin
      for (int b = 0; b < pagerank_pkg::lanes; b++) begin
        got[8*b +: 8] = mem.bytes[8'(br + 4 * c + b)];
      end
      check({name, " result in memory"}, exp_data[2*run + c], got);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    reset       = 1'b1;
    pr_req_val  = 1'b0;
    pr_req_type = pagerank_pkg::pr_rd;
    pr_req_addr = '0;
    pr_req_data = '0;
    pr_resp_rdy = 1'b1;
    for (int a = 0; a < 256; a++) begin
      mem.bytes[a] = random_byte();
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    host_read("idle read");
    run_once("run 1", 0, 1'b1, 32'h00, 32'h40);
    // new regions
    run_once("run 2", 1, 1'b1, 32'h80, 32'hc0);
    // same bases, previous result as R
    run_once("run 3", 2, 1'b0, 32'h80, 32'hc0);
    if (dut.u_asserts.hold_bad || dut.u_asserts.overlap_bad || dut.u_asserts.host_bad) begin
      $display(">>> FAIL");
      $fatal(1, "handshake assertion failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/pagerank_pkg.sv
hdl/rank_buf_if.sv
hdl/rank_sequencer.sv
hdl/rank_buffer.sv
hdl/rank_mac.sv
hdl/pagerank_scheduler.sv
testbench/tb_pagerank_mem.sv
testbench/pagerank_asserts.sv
testbench/tb_pagerank.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TB_TOP    = tb_pagerank
RTL_TOP   = pagerank_scheduler
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
